// ==== ctrl_registers.sv ====
// Exit code, hardware-counter enable and event-trigger registers
// Exit and counter enable take byte-selected writes and read back
// A write to the event offset pulses the trigger in the cycle after ack
// Other offsets read zero and ignore writes

`timescale 1ns/1ps

module ctrl_registers import soc_bus_pkg::*; (
  input  logic      clk_i,
  input  logic      arst_n_i,
  input  logic      stb_i,
  input  logic      we_i,
  input  bus_addr_t adr_i,
  input  bus_data_t dat_i,
  input  bus_sel_t  sel_i,
  output bus_data_t dat_o,
  output logic      ack_o,
  output bus_data_t exit_o,
  output bus_data_t hw_cnt_en_o,
  output logic      event_trigger_o
);

  bus_addr_t offs;
  bus_data_t exit_q;
  bus_data_t cnt_en_q;
  bus_data_t rdata_q;
  logic      ack_q;
  logic      event_q;
  logic      req;

  // Word-aligned offset within the region
  assign offs = {adr_i[BusAddrWidth-1:2], 2'b00};
  assign req  = stb_i && !ack_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ack_q    <= 1'b0;
      event_q  <= 1'b0;
      exit_q   <= '0;
      cnt_en_q <= '0;
    end else begin
      ack_q   <= req;
      // Request fields are still held during the ack cycle
      event_q <= ack_q && stb_i && we_i && (offs == CtrlEventOffs);
      if (req && we_i) begin
        for (int i = 0; i < BusSelWidth; i++) begin
          if (sel_i[i] && offs == CtrlExitOffs) begin
            exit_q[8*i +: 8] <= dat_i[8*i +: 8];
          end
          if (sel_i[i] && offs == CtrlCntEnOffs) begin
            cnt_en_q[8*i +: 8] <= dat_i[8*i +: 8];
          end
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (req) begin
      case (offs)
        CtrlExitOffs:  rdata_q <= exit_q;
        CtrlCntEnOffs: rdata_q <= cnt_en_q;
        default:       rdata_q <= '0;
      endcase
    end
  end

  assign dat_o           = rdata_q;
  assign ack_o           = ack_q;
  assign exit_o          = exit_q;
  assign hw_cnt_en_o     = cnt_en_q;
  assign event_trigger_o = event_q;

endmodule : ctrl_registers

// ==== l2_mem.sv ====
// Single-port L2 word memory behind a Wishbone slave port
// L2NumWords must be a power of two and at least 2
// Word index is the address divided by four, modulo L2NumWords
// Ack comes one cycle after stb and never stalls; contents start undefined

`timescale 1ns/1ps

module l2_mem import soc_bus_pkg::*; #(
  parameter int unsigned L2NumWords = 1024
) (
  input  logic      clk_i,
  input  logic      arst_n_i,
  input  logic      stb_i,
  input  logic      we_i,
  input  bus_addr_t adr_i,
  input  bus_data_t dat_i,
  input  bus_sel_t  sel_i,
  output bus_data_t dat_o,
  output logic      ack_o
);

  localparam int unsigned IdxWidth = $clog2(L2NumWords);

  bus_data_t           mem_q [L2NumWords];
  bus_data_t           rdata_q;
  logic                ack_q;
  logic                req;
  logic [IdxWidth-1:0] idx;

  // Request held through the ack cycle is not a new one
  assign req = stb_i && !ack_q;
  assign idx = adr_i[IdxWidth+1:2];

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= req;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req && we_i) begin
      for (int i = 0; i < BusSelWidth; i++) begin
        if (sel_i[i]) begin
          mem_q[idx][8*i +: 8] <= dat_i[8*i +: 8];
        end
      end
    end
    if (req && !we_i) begin
      rdata_q <= mem_q[idx];
    end
  end

  assign dat_o = rdata_q;
  assign ack_o = ack_q;

endmodule : l2_mem

// ==== run.sh ====
#!/bin/sh
# Build and run the subsystem testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_soc -f verilog.f

# Keep running past assertion errors so the testbench prints its verdict
out=$(./obj_dir/Vtb_soc +verilator+error+limit+1000 || true)
printf '%s\n' "$out"

printf '%s\n' "$out" | grep -qx '>>> PASS'

// ==== soc_bus_pkg.sv ====
// Bus format of the subsystem
// Single 32-bit Wishbone classic bus with byte selects
// Control offsets are relative to CtrlBase

package soc_bus_pkg;

  localparam int unsigned BusAddrWidth = 32;
  localparam int unsigned BusDataWidth = 32;
  localparam int unsigned BusSelWidth  = BusDataWidth / 8;

  typedef logic [BusAddrWidth-1:0] bus_addr_t;
  typedef logic [BusDataWidth-1:0] bus_data_t;
  typedef logic [BusSelWidth-1:0]  bus_sel_t;

  // Control register offsets
  localparam bus_addr_t CtrlExitOffs  = 32'h0000_0000;
  localparam bus_addr_t CtrlCntEnOffs = 32'h0000_0004;
  localparam bus_addr_t CtrlEventOffs = 32'h0000_0008;

endpackage : soc_bus_pkg

// ==== soc_checker.sv ====
// Reference model and comparator on the subsystem ports
// Samples on the falling clock edge, where all signals are settled
// Assumes one Wishbone transaction at a time and a UART image that starts at zero

`timescale 1ns/1ps

module soc_checker import soc_map_pkg::*; import soc_bus_pkg::*; #(
  parameter int unsigned L2NumWords = 1024
) (
  input logic      clk_i,
  input logic      arst_n_i,
  input logic      wb_cyc_i,
  input logic      wb_stb_i,
  input logic      wb_we_i,
  input bus_addr_t wb_adr_i,
  input bus_data_t wb_wdat_i,
  input bus_sel_t  wb_sel_i,
  input bus_data_t wb_rdat_i,
  input logic      wb_ack_i,
  input logic      wb_err_i,
  input logic      psel_i,
  input logic      penable_i,
  input logic      pwrite_i,
  input bus_addr_t paddr_i,
  input bus_data_t pwdata_i,
  input logic      pready_i,
  input bus_data_t exit_i,
  input bus_data_t cnt_en_i,
  input logic      event_i
);

  int          value_errs    = 0;
  int          protocol_errs = 0;
  logic        busy          = 1'b0;
  int          cnt           = 0;
  int          pready_cnt    = 0;
  soc_target_e tgt           = NONE;
  bus_addr_t   req_adr       = '0;
  bus_addr_t   offs          = '0;
  bus_data_t   req_dat       = '0;
  logic        req_we        = 1'b0;
  bus_sel_t    req_sel       = '0;
  logic        event_exp     = 1'b0;
  bus_data_t   exit_m        = '0;
  bus_data_t   cnt_en_m      = '0;
  bus_data_t   l2_img [L2NumWords] = '{default: '0};
  bus_data_t   uart_img [1024]     = '{default: '0};

  ////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////

  function automatic soc_target_e decode(bus_addr_t a);
    if (a >= DramBase && a < DramBase + DramLength)
      return L2MEM;
    if (a >= UartBase && a < UartBase + UartLength)
      return UART;
    if (a >= CtrlBase && a < CtrlBase + CtrlLength)
      return CTRL;
    return NONE;
  endfunction

  function automatic bus_data_t byte_merge(bus_data_t old, bus_data_t wdat, bus_sel_t sel);
    bus_data_t res;
    res = old;
    for (int i = 0; i < BusSelWidth; i++) begin
      if (sel[i])
        res[8*i +: 8] = wdat[8*i +: 8];
    end
    return res;
  endfunction

  // Word address modulo the memory size
  function automatic int l2_index(bus_addr_t o);
    return int'((o >> 2) % L2NumWords);
  endfunction

  function automatic bus_data_t ref_read(soc_target_e t, bus_addr_t o);
    case (t)
      L2MEM: return l2_img[l2_index(o)];
      UART:  return uart_img[o[11:2]];
      CTRL: begin
        if (o == CtrlExitOffs)
          return exit_m;
        if (o == CtrlCntEnOffs)
          return cnt_en_m;
        return '0;
      end
      default: return '0;
    endcase
  endfunction

  task automatic check_value(string name, bus_data_t exp, bus_data_t act);
    if (act !== exp) begin
      $display("error at %0t: %s expected %h, got %h", $time, name, exp, act);
      value_errs++;
    end
  endtask

  task automatic protocol_error(string what);
    $display("%0t: %s", $time, what);
    protocol_errs++;
  endtask

  task automatic start_txn();
    busy       = 1'b1;
    cnt        = 0;
    pready_cnt = -2;
    req_adr    = wb_adr_i;
    req_we     = wb_we_i;
    req_dat    = wb_wdat_i;
    req_sel    = wb_sel_i;
    tgt        = decode(wb_adr_i);
    case (tgt)
      L2MEM:   offs = wb_adr_i - DramBase;
      UART:    offs = wb_adr_i - UartBase;
      CTRL:    offs = wb_adr_i - CtrlBase;
      default: offs = wb_adr_i;
    endcase
  endtask

  task automatic check_apb();
    if (!busy || tgt != UART) begin
      protocol_error("uart_psel_o is high without a UART request");
    end else begin
      check_value("uart_paddr_o", offs, paddr_i);
      check_value("uart_pwrite_o", bus_data_t'(req_we), bus_data_t'(pwrite_i));
      if (req_we)
        check_value("uart_pwdata_o", req_dat, pwdata_i);
    end
  endtask

  task automatic finish_txn();
    logic exp_err;
    int   exp_cnt;
    exp_err = (tgt == NONE) || (tgt == UART && offs == 32'h0000_0FFC);
    exp_cnt = (tgt == UART) ? pready_cnt + 1 : 1;
    check_value("wb_ack_o", bus_data_t'(!exp_err), bus_data_t'(wb_ack_i));
    check_value("wb_err_o", bus_data_t'(exp_err), bus_data_t'(wb_err_i));
    if (cnt != exp_cnt) begin
      protocol_error($sformatf("response to address %h came after %0d cycles, not %0d",
                               req_adr, cnt, exp_cnt));
    end
    if (tgt == NONE) begin
      check_value("wb_dat_o", '0, wb_rdat_i);
    end else if (!exp_err && !req_we) begin
      check_value("wb_dat_o", ref_read(tgt, offs), wb_rdat_i);
    end else if (!exp_err) begin
      case (tgt)
        L2MEM:   l2_img[l2_index(offs)] = byte_merge(l2_img[l2_index(offs)], req_dat, req_sel);
        UART:    uart_img[offs[11:2]] = req_dat;
        default: begin
          if (offs == CtrlExitOffs)
            exit_m = byte_merge(exit_m, req_dat, req_sel);
          if (offs == CtrlCntEnOffs)
            cnt_en_m = byte_merge(cnt_en_m, req_dat, req_sel);
          // Trigger is due in the cycle after the ack
          if (offs == CtrlEventOffs)
            event_exp = 1'b1;
        end
      endcase
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Comparator
  ////////////////////////////////////////////////////////////

  always @(negedge clk_i) begin
    if (!arst_n_i) begin
      busy      = 1'b0;
      event_exp = 1'b0;
    end else begin
      check_value("event_trigger_o", bus_data_t'(event_exp), bus_data_t'(event_i));
      event_exp = 1'b0;
      if (busy) begin
        cnt++;
      end else if (wb_cyc_i && wb_stb_i) begin
        start_txn();
      end
      if (busy && psel_i && penable_i && pready_i)
        pready_cnt = cnt;
      if (psel_i)
        check_apb();
      if (wb_ack_i || wb_err_i) begin
        if (busy) begin
          finish_txn();
          busy = 1'b0;
        end else begin
          protocol_error("ack or err without a request");
        end
      end
      check_value("exit_o", exit_m, exit_i);
      check_value("hw_cnt_en_o", cnt_en_m, cnt_en_i);
    end
  end

endmodule : soc_checker

// ==== soc_map_pkg.sv ====
// Memory map of the peripheral subsystem
// Each region base is aligned to its length and regions do not overlap
// Addresses outside all regions decode to NONE and get a bus error

package soc_map_pkg;

  ////////////////////////////////////////////////////////////
  // Region bases and lengths
  ////////////////////////////////////////////////////////////

  // 1 GiB of L2 word memory aliased modulo its real size
  localparam logic [31:0] DramBase   = 32'h8000_0000;
  localparam logic [31:0] DramLength = 32'h4000_0000;

  localparam logic [31:0] UartBase   = 32'hC000_0000;
  localparam logic [31:0] UartLength = 32'h0000_1000;

  localparam logic [31:0] CtrlBase   = 32'hD000_0000;
  localparam logic [31:0] CtrlLength = 32'h0000_1000;

  ////////////////////////////////////////////////////////////
  // Target indices
  ////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    L2MEM = 2'd0,
    UART  = 2'd1,
    CTRL  = 2'd2,
    NONE  = 2'd3
  } soc_target_e;

  // NONE is not a real target
  localparam int unsigned NrTargets = 3;

endpackage : soc_map_pkg

// ==== soc_sva.sv ====
// Protocol assertions bound to the subsystem top level
// Checked on the rising clock edge outside reset

`timescale 1ns/1ps

module soc_sva (
  input logic clk_i,
  input logic arst_n_i,
  input logic stb_i,
  input logic ack_i,
  input logic err_i,
  input logic psel_i,
  input logic penable_i
);

  int fail_cnt = 0;

  ack_err_excl: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    !(ack_i && err_i))
    else begin
      $error("ack and err are high together");
      fail_cnt++;
    end

  ack_needs_stb: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    $rose(ack_i) |-> stb_i)
    else begin
      $error("ack rose without stb");
      fail_cnt++;
    end

  // Access phase only after a setup cycle
  penable_after_setup: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    $rose(penable_i) |-> $past(psel_i && !penable_i))
    else begin
      $error("penable rose without a psel setup cycle");
      fail_cnt++;
    end

endmodule : soc_sva

bind soc_top soc_sva u_sva (
  .clk_i    (clk_i         ),
  .arst_n_i (arst_n_i      ),
  .stb_i    (wb_stb_i      ),
  .ack_i    (wb_ack_o      ),
  .err_i    (wb_err_o      ),
  .psel_i   (uart_psel_o   ),
  .penable_i(uart_penable_o)
);

// ==== soc_top.sv ====
// Peripheral subsystem with one external Wishbone classic master port
// Targets are the L2 word memory, the UART over APB and the control registers
// One transaction in flight; the master holds the request until ack or err
// L2NumWords must be a non-zero power of two

`timescale 1ns/1ps

module soc_top import soc_map_pkg::*; import soc_bus_pkg::*; #(
  parameter int unsigned L2NumWords = 1024
) (
  input  logic      clk_i,
  input  logic      arst_n_i,
  // Wishbone master port
  input  logic      wb_cyc_i,
  input  logic      wb_stb_i,
  input  logic      wb_we_i,
  input  bus_addr_t wb_adr_i,
  input  bus_data_t wb_dat_i,
  input  bus_sel_t  wb_sel_i,
  output bus_data_t wb_dat_o,
  output logic      wb_ack_o,
  output logic      wb_err_o,
  // UART APB port
  output logic      uart_psel_o,
  output logic      uart_penable_o,
  output logic      uart_pwrite_o,
  output bus_addr_t uart_paddr_o,
  output bus_data_t uart_pwdata_o,
  input  bus_data_t uart_prdata_i,
  input  logic      uart_pready_i,
  input  logic      uart_pslverr_i,
  // Control outputs
  output bus_data_t exit_o,
  output bus_data_t hw_cnt_en_o,
  output logic      event_trigger_o
);

  logic [NrTargets-1:0]      tgt_stb;
  logic                      tgt_we;
  bus_addr_t                 tgt_adr;
  bus_data_t                 tgt_wdat;
  bus_sel_t                  tgt_sel;
  logic [NrTargets-1:0]      tgt_ack;
  logic                      tgt_err;
  bus_data_t [NrTargets-1:0] tgt_rdat;

  ////////////////////////////////////////////////////////////
  // Decoder
  ////////////////////////////////////////////////////////////

  soc_xbar i_soc_xbar (
    .clk_i    (clk_i   ),
    .arst_n_i (arst_n_i),
    .wb_cyc_i (wb_cyc_i),
    .wb_stb_i (wb_stb_i),
    .wb_we_i  (wb_we_i ),
    .wb_adr_i (wb_adr_i),
    .wb_dat_i (wb_dat_i),
    .wb_sel_i (wb_sel_i),
    .wb_dat_o (wb_dat_o),
    .wb_ack_o (wb_ack_o),
    .wb_err_o (wb_err_o),
    .tgt_stb_o(tgt_stb ),
    .tgt_we_o (tgt_we  ),
    .tgt_adr_o(tgt_adr ),
    .tgt_dat_o(tgt_wdat),
    .tgt_sel_o(tgt_sel ),
    .tgt_ack_i(tgt_ack ),
    .tgt_err_i(tgt_err ),
    .tgt_dat_i(tgt_rdat)
  );

  ////////////////////////////////////////////////////////////
  // Targets
  ////////////////////////////////////////////////////////////

  l2_mem #(
    .L2NumWords(L2NumWords)
  ) i_l2_mem (
    .clk_i   (clk_i          ),
    .arst_n_i(arst_n_i       ),
    .stb_i   (tgt_stb[L2MEM] ),
    .we_i    (tgt_we         ),
    .adr_i   (tgt_adr        ),
    .dat_i   (tgt_wdat       ),
    .sel_i   (tgt_sel        ),
    .dat_o   (tgt_rdat[L2MEM]),
    .ack_o   (tgt_ack[L2MEM] )
  );

  wb_to_apb i_wb_to_apb (
    .clk_i         (clk_i         ),
    .arst_n_i      (arst_n_i      ),
    .stb_i         (tgt_stb[UART] ),
    .we_i          (tgt_we        ),
    .adr_i         (tgt_adr       ),
    .dat_i         (tgt_wdat      ),
    .dat_o         (tgt_rdat[UART]),
    .ack_o         (tgt_ack[UART] ),
    .err_o         (tgt_err       ),
    .uart_psel_o   (uart_psel_o   ),
    .uart_penable_o(uart_penable_o),
    .uart_pwrite_o (uart_pwrite_o ),
    .uart_paddr_o  (uart_paddr_o  ),
    .uart_pwdata_o (uart_pwdata_o ),
    .uart_prdata_i (uart_prdata_i ),
    .uart_pready_i (uart_pready_i ),
    .uart_pslverr_i(uart_pslverr_i)
  );

  ctrl_registers i_ctrl_registers (
    .clk_i          (clk_i          ),
    .arst_n_i       (arst_n_i       ),
    .stb_i          (tgt_stb[CTRL]  ),
    .we_i           (tgt_we         ),
    .adr_i          (tgt_adr        ),
    .dat_i          (tgt_wdat       ),
    .sel_i          (tgt_sel        ),
    .dat_o          (tgt_rdat[CTRL] ),
    .ack_o          (tgt_ack[CTRL]  ),
    .exit_o         (exit_o         ),
    .hw_cnt_en_o    (hw_cnt_en_o    ),
    .event_trigger_o(event_trigger_o)
  );

  ////////////////////////////////////////////////////////////
  // Parameter checks
  ////////////////////////////////////////////////////////////

  if (L2NumWords == 0) begin : gen_l2_zero
    $error("[soc_top] L2NumWords must be non-zero");
  end

  if ((L2NumWords & (L2NumWords - 1)) != 0) begin : gen_l2_pow2
    $error("[soc_top] L2NumWords must be a power of two");
  end

endmodule : soc_top

// ==== soc_xbar.sv ====
// Wishbone classic address decoder for one master and three targets
// Request path is combinational and targets see a region-relative address
// Unmapped accesses get err one cycle after the request and zero data
// Only the UART bridge can return an error of its own

`timescale 1ns/1ps

module soc_xbar import soc_map_pkg::*; import soc_bus_pkg::*; (
  input  logic                      clk_i,
  input  logic                      arst_n_i,
  // Master side
  input  logic                      wb_cyc_i,
  input  logic                      wb_stb_i,
  input  logic                      wb_we_i,
  input  bus_addr_t                 wb_adr_i,
  input  bus_data_t                 wb_dat_i,
  input  bus_sel_t                  wb_sel_i,
  output bus_data_t                 wb_dat_o,
  output logic                      wb_ack_o,
  output logic                      wb_err_o,
  // Target side
  output logic [NrTargets-1:0]      tgt_stb_o,
  output logic                      tgt_we_o,
  output bus_addr_t                 tgt_adr_o,
  output bus_data_t                 tgt_dat_o,
  output bus_sel_t                  tgt_sel_o,
  input  logic [NrTargets-1:0]      tgt_ack_i,
  input  logic                      tgt_err_i,
  input  bus_data_t [NrTargets-1:0] tgt_dat_i
);

  soc_target_e tgt_sel;
  bus_addr_t   tgt_base;
  logic        req;
  logic        err_q;

  // Wraps below the base, so one compare covers both bounds
  function automatic logic in_region(bus_addr_t addr, bus_addr_t base, bus_addr_t len);
    return (addr - base) < len;
  endfunction

  assign req = wb_cyc_i && wb_stb_i;

  ////////////////////////////////////////////////////////////
  // Decode
  ////////////////////////////////////////////////////////////

  always_comb begin
    tgt_sel  = NONE;
    tgt_base = '0;
    if (in_region(wb_adr_i, DramBase, DramLength)) begin
      tgt_sel  = L2MEM;
      tgt_base = DramBase;
    end else if (in_region(wb_adr_i, UartBase, UartLength)) begin
      tgt_sel  = UART;
      tgt_base = UartBase;
    end else if (in_region(wb_adr_i, CtrlBase, CtrlLength)) begin
      tgt_sel  = CTRL;
      tgt_base = CtrlBase;
    end
  end

  assign tgt_we_o  = wb_we_i;
  assign tgt_adr_o = wb_adr_i - tgt_base;
  assign tgt_dat_o = wb_dat_i;
  assign tgt_sel_o = wb_sel_i;

  ////////////////////////////////////////////////////////////
  // Steering and response mux
  ////////////////////////////////////////////////////////////

  always_comb begin
    tgt_stb_o = '0;
    wb_ack_o  = 1'b0;
    wb_dat_o  = '0;
    wb_err_o  = err_q;
    case (tgt_sel)
      L2MEM: begin
        tgt_stb_o[L2MEM] = req;
        wb_ack_o         = tgt_ack_i[L2MEM];
        wb_dat_o         = tgt_dat_i[L2MEM];
      end
      UART: begin
        tgt_stb_o[UART] = req;
        wb_ack_o        = tgt_ack_i[UART];
        wb_dat_o        = tgt_dat_i[UART];
        wb_err_o        = err_q || tgt_err_i;
      end
      CTRL: begin
        tgt_stb_o[CTRL] = req;
        wb_ack_o        = tgt_ack_i[CTRL];
        wb_dat_o        = tgt_dat_i[CTRL];
      end
      default: ;
    endcase
  end

  // Error responder with one cycle per request
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      err_q <= 1'b0;
    end else begin
      err_q <= req && (tgt_sel == NONE) && !err_q;
    end
  end

endmodule : soc_xbar

// ==== tb_soc.sv ====
// Testbench for the peripheral subsystem
// Drives the Wishbone master port and models the UART as an APB slave
// The checker instance does the comparing; this module ends the run
// UART slave image starts at zero and offset 0xFFC answers with pslverr

`timescale 1ns/1ps

module tb_soc import soc_map_pkg::*; import soc_bus_pkg::*; ();

  localparam int unsigned L2Words       = 64;
  localparam int          NumTxn        = 58;
  localparam int          TimeoutCycles = 40 * NumTxn;

  logic      clk_i = 1'b0;
  logic      arst_n_i;
  logic      wb_cyc_i;
  logic      wb_stb_i;
  logic      wb_we_i;
  bus_addr_t wb_adr_i;
  bus_data_t wb_dat_i;
  bus_sel_t  wb_sel_i;
  bus_data_t wb_dat_o;
  logic      wb_ack_o;
  logic      wb_err_o;
  logic      uart_psel_o;
  logic      uart_penable_o;
  logic      uart_pwrite_o;
  bus_addr_t uart_paddr_o;
  bus_data_t uart_pwdata_o;
  bus_data_t uart_prdata_i  = '0;
  logic      uart_pready_i  = 1'b0;
  logic      uart_pslverr_i = 1'b0;
  bus_data_t exit_o;
  bus_data_t hw_cnt_en_o;
  logic      event_trigger_o;

  int        seed   = 39415;
  int        cycles = 0;
  int        waits  = 0;
  bus_data_t uart_img [1024] = '{default: '0};

  soc_top #(
    .L2NumWords(L2Words)
  ) dut (.*);

  soc_checker #(
    .L2NumWords(L2Words)
  ) u_checker (
    .clk_i    (clk_i          ),
    .arst_n_i (arst_n_i       ),
    .wb_cyc_i (wb_cyc_i       ),
    .wb_stb_i (wb_stb_i       ),
    .wb_we_i  (wb_we_i        ),
    .wb_adr_i (wb_adr_i       ),
    .wb_wdat_i(wb_dat_i       ),
    .wb_sel_i (wb_sel_i       ),
    .wb_rdat_i(wb_dat_o       ),
    .wb_ack_i (wb_ack_o       ),
    .wb_err_i (wb_err_o       ),
    .psel_i   (uart_psel_o    ),
    .penable_i(uart_penable_o ),
    .pwrite_i (uart_pwrite_o  ),
    .paddr_i  (uart_paddr_o   ),
    .pwdata_i (uart_pwdata_o  ),
    .pready_i (uart_pready_i  ),
    .exit_i   (exit_o         ),
    .cnt_en_i (hw_cnt_en_o    ),
    .event_i  (event_trigger_o)
  );

  always #4 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycles++;
    if (cycles == TimeoutCycles) begin
      $display("timeout: the tests did not finish within %0d cycles", TimeoutCycles);
      $display(">>> FAIL");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////
  // APB slave for the UART with 0 to 3 wait cycles
  ////////////////////////////////////////////////////////////

  always @(posedge clk_i) begin
    #1;
    uart_pready_i  = 1'b0;
    uart_pslverr_i = 1'b0;
    if (uart_psel_o && !uart_penable_o) begin
      waits = {$random(seed)} % 4;
    end else if (uart_psel_o && uart_penable_o) begin
      if (waits == 0) begin
        uart_pready_i  = 1'b1;
        uart_pslverr_i = (uart_paddr_o == 32'h0000_0FFC);
        uart_prdata_i  = uart_img[uart_paddr_o[11:2]];
        if (uart_pwrite_o && !uart_pslverr_i) begin
          uart_img[uart_paddr_o[11:2]] = uart_pwdata_o;
        end
      end else begin
        waits--;
      end
    end
  end

  // One Wishbone classic cycle held until ack or err
  task automatic wb_access(bus_addr_t addr, logic we, bus_data_t dat, bus_sel_t sel);
    @(posedge clk_i);
    #1;
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    wb_we_i  = we;
    wb_adr_i = addr;
    wb_dat_i = dat;
    wb_sel_i = sel;
    do begin
      @(negedge clk_i);
    end while (!(wb_ack_o || wb_err_o));
    @(posedge clk_i);
    #1;
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
  endtask

  ////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////

  initial begin
    bus_addr_t l2_addr [8];
    bus_addr_t uart_addr [6];
    int        errs;
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
    wb_adr_i = '0;
    wb_dat_i = '0;
    wb_sel_i = '0;
    arst_n_i = 1'b0;
    repeat (4) @(posedge clk_i);
    #1;
    arst_n_i = 1'b1;

    // L2 full words, byte merges, reads and aliased reads
    for (int i = 0; i < 8; i++) begin
      l2_addr[i] = DramBase + ({$random(seed)} & 32'h000F_FFFC);
      wb_access(l2_addr[i], 1'b1, $random(seed), 4'hF);
    end
    for (int i = 0; i < 8; i++) begin
      wb_access(l2_addr[i], 1'b1, $random(seed), bus_sel_t'($random(seed)));
    end
    for (int i = 0; i < 8; i++) begin
      wb_access(l2_addr[i], 1'b0, '0, 4'hF);
      wb_access(l2_addr[i] + L2Words * 4 * (i + 1), 1'b0, '0, 4'hF);
    end

    // Control registers
    wb_access(CtrlBase + CtrlExitOffs, 1'b1, $random(seed), 4'hF);
    wb_access(CtrlBase + CtrlExitOffs, 1'b1, $random(seed), 4'b0101);
    wb_access(CtrlBase + CtrlCntEnOffs, 1'b1, $random(seed), 4'hF);
    wb_access(CtrlBase + CtrlCntEnOffs, 1'b1, $random(seed), 4'b0010);
    wb_access(CtrlBase + CtrlExitOffs, 1'b0, '0, 4'hF);
    wb_access(CtrlBase + CtrlCntEnOffs, 1'b0, '0, 4'hF);
    wb_access(CtrlBase + 32'h0000_000C, 1'b0, '0, 4'hF);
    wb_access(CtrlBase + 32'h0000_0010, 1'b0, '0, 4'hF);
    wb_access(CtrlBase + CtrlEventOffs, 1'b1, $random(seed), 4'hF);
    wb_access(CtrlBase + CtrlEventOffs, 1'b0, '0, 4'hF);

    // UART under random wait states
    for (int i = 0; i < 6; i++) begin
      uart_addr[i] = UartBase + ({$random(seed)} & 32'h0000_07FC);
      wb_access(uart_addr[i], 1'b1, $random(seed), 4'hF);
    end
    for (int i = 0; i < 6; i++) begin
      wb_access(uart_addr[i], 1'b0, '0, 4'hF);
    end

    // Slave error and unmapped address
    wb_access(UartBase + 32'h0000_0FFC, 1'b1, $random(seed), 4'hF);
    wb_access(UartBase + 32'h0000_0FFC, 1'b0, '0, 4'hF);
    wb_access(32'h1000_0000, 1'b1, $random(seed), 4'hF);
    wb_access(32'h1000_0000, 1'b0, '0, 4'hF);

    repeat (4) @(posedge clk_i);
    errs = u_checker.value_errs + u_checker.protocol_errs + dut.u_sva.fail_cnt;
    $display("errors: %0d value, %0d protocol, %0d assertion",
             u_checker.value_errs, u_checker.protocol_errs, dut.u_sva.fail_cnt);
    if (errs == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule : tb_soc

// ==== verilog.f ====
soc_map_pkg.sv
soc_bus_pkg.sv
soc_xbar.sv
l2_mem.sv
wb_to_apb.sv
ctrl_registers.sv
soc_top.sv
soc_sva.sv
soc_checker.sv
tb_soc.sv

// ==== wb_to_apb.sv ====
// Wishbone slave to APB master bridge for the UART
// One access at a time with a setup phase and an access phase until pready
// Ack or err goes back one cycle after the pready cycle
// Byte selects are ignored because the APB target is word-wide

`timescale 1ns/1ps

module wb_to_apb import soc_bus_pkg::*; (
  input  logic      clk_i,
  input  logic      arst_n_i,
  // Wishbone side
  input  logic      stb_i,
  input  logic      we_i,
  input  bus_addr_t adr_i,
  input  bus_data_t dat_i,
  output bus_data_t dat_o,
  output logic      ack_o,
  output logic      err_o,
  // APB side
  output logic      uart_psel_o,
  output logic      uart_penable_o,
  output logic      uart_pwrite_o,
  output bus_addr_t uart_paddr_o,
  output bus_data_t uart_pwdata_o,
  input  bus_data_t uart_prdata_i,
  input  logic      uart_pready_i,
  input  logic      uart_pslverr_i
);

  typedef enum logic [1:0] {
    StIdle,
    StSetup,
    StAccess
  } state_e;

  state_e    state_q;
  logic      ack_q;
  logic      err_q;
  logic      we_q;
  bus_addr_t adr_q;
  bus_data_t wdata_q;
  bus_data_t rdata_q;

  ////////////////////////////////////////////////////////////
  // APB phase FSM
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= StIdle;
      ack_q   <= 1'b0;
      err_q   <= 1'b0;
    end else begin
      ack_q <= 1'b0;
      err_q <= 1'b0;
      case (state_q)
        StIdle: begin
          // Master still holds stb while the response is out
          if (stb_i && !ack_q && !err_q) begin
            state_q <= StSetup;
          end
        end
        StSetup: begin
          state_q <= StAccess;
        end
        StAccess: begin
          if (uart_pready_i) begin
            state_q <= StIdle;
            ack_q   <= !uart_pslverr_i;
            err_q   <= uart_pslverr_i;
          end
        end
        default: begin
          state_q <= StIdle;
        end
      endcase
    end
  end

  // Request and read data capture
  always_ff @(posedge clk_i) begin
    if (state_q == StIdle && stb_i) begin
      we_q    <= we_i;
      adr_q   <= adr_i;
      wdata_q <= dat_i;
    end
    if (state_q == StAccess && uart_pready_i) begin
      rdata_q <= uart_prdata_i;
    end
  end

  assign uart_psel_o    = (state_q != StIdle);
  assign uart_penable_o = (state_q == StAccess);
  assign uart_pwrite_o  = we_q;
  assign uart_paddr_o   = adr_q;
  assign uart_pwdata_o  = wdata_q;

  assign dat_o = rdata_q;
  assign ack_o = ack_q;
  assign err_o = err_q;

endmodule : wb_to_apb
